// ==== design/layer_seq_defines.svh ====
// ---------------------------------------------------------------------------
// layer sequencer constants
// store depth, writeback delay and configuration field widths
// ---------------------------------------------------------------------------

`ifndef LAYER_SEQ_DEFINES_SVH
`define LAYER_SEQ_DEFINES_SVH

// layer store
`define LSEQ_FIFO_DEPTH 10
`define LSEQ_CNT_BITS $clog2(`LSEQ_FIFO_DEPTH + 1)   // occupancy and layer index

// cycles from end of compute to layer done
`define LSEQ_WRITEBACK_DELAY 2

// configuration field widths
`define LSEQ_IMG_BITS 9     // image width and height
`define LSEQ_K_BITS 3       // kernel size, strides, pooling kernel
`define LSEQ_CH_BITS 8      // input and output channel counts

// activation memory bankset index
`define LSEQ_BANK_BITS 2

`endif

// ==== design/layer_seq_pkg.sv ====
// ---------------------------------------------------------------------------
// layer sequencer types
// layer configuration record, controller states and bankset index
// ---------------------------------------------------------------------------

`default_nettype none

`include "layer_seq_defines.svh"

package layer_seq_pkg;

   // one convolution layer as stored by the host and shown to compute
   typedef struct packed {
      logic [`LSEQ_IMG_BITS-1:0] imagewidth;
      logic [`LSEQ_IMG_BITS-1:0] imageheight;
      logic [`LSEQ_K_BITS-1:0]   k;
      logic [`LSEQ_CH_BITS-1:0]  ni;
      logic [`LSEQ_CH_BITS-1:0]  no;
      logic [`LSEQ_K_BITS-1:0]   stride_width;
      logic [`LSEQ_K_BITS-1:0]   stride_height;
      logic                      padding_type;
      logic                      pooling_enable;    // pooling and skip pass through
      logic                      pooling_type;
      logic [`LSEQ_K_BITS-1:0]   pooling_kernel;
      logic                      skip_in;
      logic                      skip_out;
   } layer_cfg_t;

   typedef enum logic [2:0] {
      IDLE,
      FETCH,        // pop head layer
      LATCH,        // strobe new layer into compute
      COMPUTE,      // wait for tile buffer
      WRITEBACK,    // fixed delay
      DONE
   } seq_state_e;

   typedef logic [`LSEQ_BANK_BITS-1:0] bank_idx_t;

endpackage

`default_nettype wire

// ==== design/layer_cfg_fifo.sv ====
// ---------------------------------------------------------------------------
// circular layer store
// host pushes fill the store, each pop moves the head entry back to the tail
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "layer_seq_defines.svh"

module layer_cfg_fifo
   import layer_seq_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      push_i,
   input  layer_cfg_t                push_cfg_i,
   input  logic                      pop_i,
   output layer_cfg_t                head_cfg_o,
   output logic [`LSEQ_CNT_BITS-1:0] count_o
);

   localparam int unsigned ptr_bits = $clog2(`LSEQ_FIFO_DEPTH);

   typedef logic [ptr_bits-1:0] ptr_t;

   layer_cfg_t                mem_q [`LSEQ_FIFO_DEPTH];
   ptr_t                      rd_ptr_q;
   ptr_t                      wr_ptr_q;
   logic [`LSEQ_CNT_BITS-1:0] count_q;

   logic       full;
   logic       empty;
   logic       do_push;
   logic       do_pop;
   logic       wr_en;
   layer_cfg_t wr_data;

   // pointer wrap at the last slot
   function automatic ptr_t ptr_inc(input ptr_t ptr);
      ptr_t nxt;
      if (ptr == ptr_t'(`LSEQ_FIFO_DEPTH - 1)) begin
         nxt = '0;
      end else begin
         nxt = ptr + 1'b1;
      end
      return nxt;
   endfunction

   assign full  = (count_q == (`LSEQ_CNT_BITS)'(`LSEQ_FIFO_DEPTH));
   assign empty = (count_q == '0);

   assign do_pop  = pop_i && !empty;
   assign do_push = push_i && !full && !do_pop;   // pop wins, host never overlaps

   // a pop recirculates the old head into the tail slot
   assign wr_en   = do_push || do_pop;
   assign wr_data = do_pop ? mem_q[rd_ptr_q] : push_cfg_i;

   // ------------------------------------------------------------------------
   // storage
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i) begin
      if (wr_en) begin
         mem_q[wr_ptr_q] <= wr_data;
      end
   end

   // ------------------------------------------------------------------------
   // pointers and occupancy
   // ------------------------------------------------------------------------
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         rd_ptr_q <= '0;
         wr_ptr_q <= '0;
         count_q  <= '0;
      end else begin
         if (wr_en) begin
            wr_ptr_q <= ptr_inc(wr_ptr_q);
         end
         if (do_pop) begin
            rd_ptr_q <= ptr_inc(rd_ptr_q);   // count stays, entry went to tail
         end
         if (do_push) begin
            count_q <= count_q + 1'b1;
         end
      end
   end

   assign head_cfg_o = mem_q[rd_ptr_q];
   assign count_o    = count_q;

endmodule

`default_nettype wire

// ==== design/layer_step_fsm.sv ====
// ---------------------------------------------------------------------------
// layer run controller
// steps once through the stored layers: pop, latch, compute wait, writeback
// and drives the compute strobes and activation memory bankset selection
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "layer_seq_defines.svh"

module layer_step_fsm
   import layer_seq_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_ni,
   input  logic                      compute_disable_i,
   input  logic                      tilebuffer_done_i,
   input  logic [`LSEQ_CNT_BITS-1:0] layer_count_i,
   input  layer_cfg_t                head_cfg_i,
   output logic                      fifo_pop_o,
   output logic                      compute_latch_new_layer_o,
   output logic                      compute_soft_reset_o,
   output logic                      compute_done_o,
   output layer_cfg_t                layer_cfg_o,
   output bank_idx_t                 readbank_o,
   output bank_idx_t                 writebank_o
);

   localparam int unsigned timer_bits =
      (`LSEQ_WRITEBACK_DELAY > 1) ? $clog2(`LSEQ_WRITEBACK_DELAY) : 1;
   localparam logic [timer_bits-1:0] timer_last = timer_bits'(`LSEQ_WRITEBACK_DELAY - 1);

   seq_state_e                state_q;
   seq_state_e                state_d;
   logic [`LSEQ_CNT_BITS-1:0] layer_idx_q;   // layer within the current run
   logic [`LSEQ_CNT_BITS-1:0] layer_idx_d;
   logic [timer_bits-1:0]     timer_q;
   logic [timer_bits-1:0]     timer_d;
   logic                      run_done_q;    // run finished since last disable
   logic                      run_done_d;
   layer_cfg_t                layer_cfg_q;
   bank_idx_t                 readbank_q;
   bank_idx_t                 writebank_q;

   logic start_run;
   logic layers_left;
   logic run_en;

   assign run_en      = !compute_disable_i;
   assign start_run   = run_en && !run_done_q && (layer_count_i != '0);
   assign layers_left = (layer_idx_q < layer_count_i);   // index already counts latched layers

   // ------------------------------------------------------------------------
   // next state
   // ------------------------------------------------------------------------
   always_comb begin : next_state
      state_d     = state_q;
      layer_idx_d = layer_idx_q;
      timer_d     = timer_q;
      run_done_d  = run_done_q;

      unique case (state_q)
         IDLE: begin
            layer_idx_d = '0;
            if (start_run) begin
               state_d = FETCH;
            end
         end
         FETCH: state_d = LATCH;
         LATCH: begin
            state_d     = COMPUTE;
            layer_idx_d = layer_idx_q + 1'b1;
         end
         COMPUTE: begin
            if (tilebuffer_done_i) begin
               state_d = WRITEBACK;
               timer_d = '0;
            end
         end
         WRITEBACK: begin
            if (timer_q == timer_last) begin
               state_d = layers_left ? FETCH : DONE;
            end else begin
               timer_d = timer_q + 1'b1;
            end
         end
         DONE: begin
            state_d    = IDLE;
            run_done_d = 1'b1;
         end
         default: state_d = IDLE;
      endcase

      // disable aborts any run and rearms the start
      if (compute_disable_i) begin
         state_d    = IDLE;
         run_done_d = 1'b0;
      end
   end

   // ------------------------------------------------------------------------
   // strobes
   // ------------------------------------------------------------------------
   assign fifo_pop_o                = run_en && (state_q == FETCH);
   assign compute_latch_new_layer_o = run_en && (state_q == LATCH);
   assign compute_soft_reset_o      = compute_latch_new_layer_o && (layer_idx_q == '0);
   assign compute_done_o            = run_en && (state_q == DONE);

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         state_q     <= IDLE;
         layer_idx_q <= '0;
         timer_q     <= '0;
         run_done_q  <= 1'b0;
      end else begin
         state_q     <= state_d;
         layer_idx_q <= layer_idx_d;
         timer_q     <= timer_d;
         run_done_q  <= run_done_d;
      end
   end

   // current layer and banksets, both held between runs
   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         layer_cfg_q <= '0;
         readbank_q  <= bank_idx_t'(1);
         writebank_q <= bank_idx_t'(0);
      end else begin
         if (fifo_pop_o) begin
            layer_cfg_q <= head_cfg_i;   // visible during the latch cycle
         end
         if (compute_latch_new_layer_o) begin
            readbank_q  <= bank_idx_t'(layer_idx_q[0]);    // ping-pong between sets 0 and 1
            writebank_q <= bank_idx_t'(!layer_idx_q[0]);
         end
      end
   end

   assign layer_cfg_o = layer_cfg_q;
   assign readbank_o  = readbank_q;
   assign writebank_o = writebank_q;

endmodule

`default_nettype wire

// ==== design/layer_sequencer.sv ====
// ---------------------------------------------------------------------------
// layer sequencer top
// circular layer store feeding the run controller of the convolution engine
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "layer_seq_defines.svh"

module layer_sequencer
   import layer_seq_pkg::*;
(
   input  logic       clk_i,
   input  logic       rst_ni,
   input  logic       store_i,
   input  layer_cfg_t layer_cfg_i,
   input  logic       compute_disable_i,
   input  logic       tilebuffer_done_i,
   output logic       fifo_pop_o,
   output logic       compute_latch_new_layer_o,
   output logic       compute_soft_reset_o,
   output layer_cfg_t layer_cfg_o,
   output bank_idx_t  readbank_o,
   output bank_idx_t  writebank_o,
   output logic       compute_done_o
);

   logic                      push;
   logic                      pop;
   layer_cfg_t                head_cfg;
   logic [`LSEQ_CNT_BITS-1:0] layer_count;

   assign push       = store_i && compute_disable_i;   // host writes only while compute is off
   assign fifo_pop_o = pop;

   layer_cfg_fifo i_layer_store (
      .clk_i      (clk_i),
      .rst_ni     (rst_ni),
      .push_i     (push),
      .push_cfg_i (layer_cfg_i),
      .pop_i      (pop),
      .head_cfg_o (head_cfg),
      .count_o    (layer_count)
   );

   layer_step_fsm i_step_fsm (
      .clk_i                     (clk_i),
      .rst_ni                    (rst_ni),
      .compute_disable_i         (compute_disable_i),
      .tilebuffer_done_i         (tilebuffer_done_i),
      .layer_count_i             (layer_count),
      .head_cfg_i                (head_cfg),
      .fifo_pop_o                (pop),
      .compute_latch_new_layer_o (compute_latch_new_layer_o),
      .compute_soft_reset_o      (compute_soft_reset_o),
      .compute_done_o            (compute_done_o),
      .layer_cfg_o               (layer_cfg_o),
      .readbank_o                (readbank_o),
      .writebank_o               (writebank_o)
   );

endmodule

`default_nettype wire

// ==== testbench/layer_sequencer_assertions.sv ====
// ---------------------------------------------------------------------------
// layer sequencer protocol checker
// strobe ordering and bankset rules, bound to the top level
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module layer_sequencer_assertions
   import layer_seq_pkg::*;
(
   input logic      clk_i,
   input logic      rst_ni,
   input logic      compute_disable_i,
   input logic      fifo_pop_i,
   input logic      latch_i,
   input logic      soft_reset_i,
   input bank_idx_t readbank_i,
   input bank_idx_t writebank_i
);

   // one flag per property, read by the testbench
   logic pop_latch_fail  = 1'b0;
   logic soft_reset_fail = 1'b0;
   logic bank_fail       = 1'b0;
   logic disabled_fail   = 1'b0;

   logic latched_q;   // at least one latch since reset

   always_ff @(posedge clk_i or negedge rst_ni) begin
      if (!rst_ni) begin
         latched_q <= 1'b0;
      end else if (latch_i) begin
         latched_q <= 1'b1;
      end
   end

   // a disable right after the pop aborts the run instead
   pop_then_latch: assert property (@(posedge clk_i) disable iff (!rst_ni)
      fifo_pop_i |=> (latch_i || compute_disable_i))
      else begin
         pop_latch_fail = 1'b1;
         $error("latch did not follow pop by one cycle");
      end

   soft_reset_with_latch: assert property (@(posedge clk_i) disable iff (!rst_ni)
      soft_reset_i |-> latch_i)
      else begin
         soft_reset_fail = 1'b1;
         $error("soft reset without latch");
      end

   banks_differ: assert property (@(posedge clk_i) disable iff (!rst_ni)
      latched_q |-> (readbank_i != writebank_i))
      else begin
         bank_fail = 1'b1;
         $error("read and write bankset are equal");
      end

   no_latch_disabled: assert property (@(posedge clk_i) disable iff (!rst_ni)
      compute_disable_i |-> !latch_i)
      else begin
         disabled_fail = 1'b1;
         $error("latch while compute is disabled");
      end

endmodule

bind layer_sequencer layer_sequencer_assertions i_assertions (
   .clk_i             (clk_i),
   .rst_ni            (rst_ni),
   .compute_disable_i (compute_disable_i),
   .fifo_pop_i        (fifo_pop_o),
   .latch_i           (compute_latch_new_layer_o),
   .soft_reset_i      (compute_soft_reset_o),
   .readbank_i        (readbank_o),
   .writebank_i       (writebank_o)
);

`default_nettype wire

// ==== testbench/layer_sequencer_tb.sv ====
// ---------------------------------------------------------------------------
// layer sequencer testbench
// random layers from an LFSR, queue model of the store, cycle-exact checks
// ---------------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

`include "layer_seq_defines.svh"

module layer_sequencer_tb
   import layer_seq_pkg::*;
();

   localparam int wait_limit = 64;   // cycles per wait loop

   logic       clk_i = 1'b0;
   logic       rst_ni;
   logic       store_i;
   layer_cfg_t layer_cfg_i;
   logic       compute_disable_i;
   logic       tilebuffer_done_i;
   logic       fifo_pop_o;
   logic       compute_latch_new_layer_o;
   logic       compute_soft_reset_o;
   layer_cfg_t layer_cfg_o;
   bank_idx_t  readbank_o;
   bank_idx_t  writebank_o;
   logic       compute_done_o;

   logic [31:0] lfsr_q = 32'haaea;
   layer_cfg_t  model_q [$];         // stored layers in store order

   always #5 clk_i = ~clk_i;

   layer_sequencer dut (
      .clk_i                     (clk_i),
      .rst_ni                    (rst_ni),
      .store_i                   (store_i),
      .layer_cfg_i               (layer_cfg_i),
      .compute_disable_i         (compute_disable_i),
      .tilebuffer_done_i         (tilebuffer_done_i),
      .fifo_pop_o                (fifo_pop_o),
      .compute_latch_new_layer_o (compute_latch_new_layer_o),
      .compute_soft_reset_o      (compute_soft_reset_o),
      .layer_cfg_o               (layer_cfg_o),
      .readbank_o                (readbank_o),
      .writebank_o               (writebank_o),
      .compute_done_o            (compute_done_o)
   );

   // ------------------------------------------------------------------------
   // random numbers and reporting
   // ------------------------------------------------------------------------
   function automatic logic [31:0] lfsr_step(input logic [31:0] state);
      logic [31:0] nxt;
      nxt = state >> 1;
      if (state[0]) begin
         nxt = nxt ^ 32'h8020_0003;
      end
      return nxt;
   endfunction

   function automatic logic [31:0] take_bits(input int unsigned count);
      logic [31:0] value;
      value = '0;
      for (int unsigned b = 0; b < count; b++) begin
         lfsr_q = lfsr_step(lfsr_q);   // one step per bit
         value  = {value[30:0], lfsr_q[0]};
      end
      return value;
   endfunction

   function automatic layer_cfg_t random_cfg();
      layer_cfg_t cfg;
      cfg.imagewidth     = (`LSEQ_IMG_BITS)'(take_bits(`LSEQ_IMG_BITS));
      cfg.imageheight    = (`LSEQ_IMG_BITS)'(take_bits(`LSEQ_IMG_BITS));
      cfg.k              = (`LSEQ_K_BITS)'(take_bits(`LSEQ_K_BITS));
      cfg.ni             = (`LSEQ_CH_BITS)'(take_bits(`LSEQ_CH_BITS));
      cfg.no             = (`LSEQ_CH_BITS)'(take_bits(`LSEQ_CH_BITS));
      cfg.stride_width   = (`LSEQ_K_BITS)'(take_bits(`LSEQ_K_BITS));
      cfg.stride_height  = (`LSEQ_K_BITS)'(take_bits(`LSEQ_K_BITS));
      cfg.padding_type   = 1'(take_bits(1));
      cfg.pooling_enable = 1'(take_bits(1));
      cfg.pooling_type   = 1'(take_bits(1));
      cfg.pooling_kernel = (`LSEQ_K_BITS)'(take_bits(`LSEQ_K_BITS));
      cfg.skip_in        = 1'(take_bits(1));
      cfg.skip_out       = 1'(take_bits(1));
      return cfg;
   endfunction

   task automatic stop_on_error();
      $display("Simulation failed");
      $fatal(1, "stopped at first error");
   endtask

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("mismatch %s: expected %0h, actual %0h", name, expected, actual);
         stop_on_error();
      end
   endtask

   // bound checker flags a failed property
   always @(negedge clk_i) begin
      if (dut.i_assertions.pop_latch_fail || dut.i_assertions.soft_reset_fail ||
          dut.i_assertions.bank_fail || dut.i_assertions.disabled_fail) begin
         $display("a protocol assertion in the bound checker failed");
         stop_on_error();
      end
   end

   // ------------------------------------------------------------------------
   // stimulus helpers
   // ------------------------------------------------------------------------
   task automatic next_cycle();
      @(posedge clk_i);
      #1;   // drive point
   endtask

   task automatic check_quiet(input string name);
      check_value({name, " pop"}, 64'(0), 64'(fifo_pop_o));
      check_value({name, " latch"}, 64'(0), 64'(compute_latch_new_layer_o));
      check_value({name, " done"}, 64'(0), 64'(compute_done_o));
   endtask

   // returns at the negedge where the strobe is seen, cycles counts negedges
   task automatic wait_strobe(input logic want_done, input string what, output int cycles);
      logic seen;
      cycles = 0;
      seen   = 1'b0;
      while (!seen) begin
         @(negedge clk_i);
         cycles++;
         check_value({what, " latch"}, 64'(0), 64'(compute_latch_new_layer_o));
         if (want_done) begin
            check_value({what, " pop"}, 64'(0), 64'(fifo_pop_o));
            seen = compute_done_o;
         end else begin
            check_value({what, " done"}, 64'(0), 64'(compute_done_o));
            seen = fifo_pop_o;
         end
         if (!seen && cycles >= wait_limit) begin
            $display("timeout: %s did not occur within %0d cycles", what, wait_limit);
            stop_on_error();
         end
      end
   endtask

   task automatic store_layers(input int unsigned count);
      layer_cfg_t cfg;
      for (int unsigned k = 0; k < count; k++) begin
         cfg = random_cfg();
         next_cycle();
         store_i     = 1'b1;
         layer_cfg_i = cfg;
         if (model_q.size() < `LSEQ_FIFO_DEPTH) begin
            model_q.push_back(cfg);   // full store drops the push
         end
      end
      next_cycle();
      store_i = 1'b0;
   endtask

   task automatic disable_compute();
      next_cycle();
      compute_disable_i = 1'b1;
   endtask

   task automatic run_layers(input string name);
      int unsigned n;
      int unsigned delay;
      int          cycles;
      layer_cfg_t  exp_cfg;
      n = model_q.size();
      next_cycle();
      compute_disable_i = 1'b0;
      wait_strobe(1'b0, {name, " first pop"}, cycles);
      for (int unsigned i = 0; i < n; i++) begin
         exp_cfg = model_q.pop_front();
         model_q.push_back(exp_cfg);   // recirculated to the tail
         next_cycle();
         @(negedge clk_i);
         check_value({name, " latch"}, 64'(1), 64'(compute_latch_new_layer_o));
         check_value({name, " soft reset"}, 64'(i == 0), 64'(compute_soft_reset_o));
         check_value({name, " layer cfg"}, 64'(exp_cfg), 64'(layer_cfg_o));
         delay = take_bits(3);
         next_cycle();
         repeat (delay) begin
            @(negedge clk_i);
            check_quiet({name, " compute"});
            next_cycle();
         end
         tilebuffer_done_i = 1'b1;
         @(negedge clk_i);
         check_value({name, " readbank"}, 64'(i % 2), 64'(readbank_o));
         check_value({name, " writebank"}, 64'((i + 1) % 2), 64'(writebank_o));
         next_cycle();
         tilebuffer_done_i = 1'b0;
         wait_strobe(i == n - 1, {name, " pop or done after writeback"}, cycles);
         check_value({name, " writeback delay"}, 64'(`LSEQ_WRITEBACK_DELAY + 1),
                     64'(cycles));
      end
   endtask

   // done was seen once, nothing may follow while enabled
   task automatic idle_after_run(input string name);
      repeat (12) begin
         @(negedge clk_i);
         check_quiet({name, " idle"});
      end
   endtask

   // ------------------------------------------------------------------------
   // test sequence
   // ------------------------------------------------------------------------
   initial begin : main
      rst_ni            = 1'b0;
      store_i           = 1'b0;
      layer_cfg_i       = '0;
      compute_disable_i = 1'b1;
      tilebuffer_done_i = 1'b0;
      repeat (10) @(posedge clk_i);
      #1;
      rst_ni = 1'b1;
      @(negedge clk_i);
      check_quiet("reset");
      check_value("reset soft reset", 64'(0), 64'(compute_soft_reset_o));
      check_value("reset readbank", 64'(1), 64'(readbank_o));
      check_value("reset writebank", 64'(0), 64'(writebank_o));
      check_value("reset layer cfg", 64'(0), 64'(layer_cfg_o));

      store_layers(take_bits(4) % 10 + 1);
      run_layers("run1");
      idle_after_run("run1");

      disable_compute();   // same order again
      run_layers("run2");
      idle_after_run("run2");

      for (int r = 3; r <= 5; r++) begin
         disable_compute();
         store_layers(take_bits(4) % 10 + 1);   // appended after the old layers
         run_layers($sformatf("run%0d", r));
         idle_after_run($sformatf("run%0d", r));
      end

      $display("Simulation completed successfully");
      $finish;
   end

endmodule

`default_nettype wire

// ==== layer_sequencer.f ====
+incdir+design
design/layer_seq_pkg.sv
design/layer_cfg_fifo.sv
design/layer_step_fsm.sv
design/layer_sequencer.sv
testbench/layer_sequencer_assertions.sv
testbench/layer_sequencer_tb.sv

// ==== Makefile ====
# Verilator build and run of the layer sequencer testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       ?= layer_sequencer_tb
FILELIST  ?= layer_sequencer.f
BUILD_DIR ?= obj_dir
PASS_MSG  := Simulation completed successfully

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)
